/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= tb.f
TB_TOP    ?= tb_mcu_cmd
RTL_TOP   ?= mcu_cmd_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -Wno-fatal -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; echo "$$out"; echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(BUILD_DIR)

/* source/addr_pointer.sv */
`timescale 1ns/1ps

module addr_pointer import mcu_cmd_pkg::*; #(
  parameter int ptr_w = 24
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  load,
  input  logic                  inc,
  input  logic [7:0]            param_data,
  input  logic [byte_cnt_w-1:0] byte_cnt,
  output logic [ptr_w-1:0]      ptr
);

  logic             in_range;
  logic             first;
  logic [ptr_w+7:0] ins_wide;
  logic [ptr_w+7:0] mask_wide;
  logic [ptr_w-1:0] ptr_next;

  // byte 2 lands in the top byte, later bytes walk down
  always_comb begin
    int last_pos;
    int pos;
    int shift;
    last_pos  = (ptr_w + 7) / 8 - 1;
    pos       = int'(byte_cnt) - 2;
    in_range  = (pos >= 0) && (pos <= last_pos);
    first     = (pos == 0);
    shift     = in_range ? (last_pos - pos) * 8 : 0;
    ins_wide  = {{ptr_w{1'b0}}, param_data} << shift;
    mask_wide = {{ptr_w{1'b0}}, 8'hff} << shift;
    if (first) begin
      ptr_next = ins_wide[ptr_w-1:0];
    end else begin
      ptr_next = (ptr & ~mask_wide[ptr_w-1:0]) | ins_wide[ptr_w-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ptr <= '0;
    end else if (load && in_range) begin
      ptr <= ptr_next;
    end else if (inc) begin
      ptr <= ptr + 1'b1;
    end
  end

endmodule

/* source/cmd_decode.sv */
`timescale 1ns/1ps

module cmd_decode import mcu_cmd_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  cmd_ready,
  input  logic                  param_ready,
  input  logic [7:0]            cmd_data,
  input  logic [7:0]            param_data,
  input  logic [byte_cnt_w-1:0] byte_cnt,
  input  logic                  busy,
  output logic [2:0]            mapper,
  output logic [mask_w-1:0]     rom_mask,
  output logic [mask_w-1:0]     sram_mask,
  output logic [7:0]            featurebits,
  output logic [num_ptr-1:0]    ptr_load,
  output logic                  rd_start,
  output logic                  wr_start,
  output logic [1:0]            xfer_target,
  output logic                  xfer_incr,
  output logic [7:0]            wr_data
);

  cmd_word_u cmd;

  assign cmd = cmd_data;

  // masks arrive msb first in bytes 2..4
  function automatic logic [mask_w-1:0] load_mask_byte(
    input logic [mask_w-1:0]     cur,
    input logic [7:0]            data,
    input logic [byte_cnt_w-1:0] cnt
  );
    logic [mask_w-1:0] res;
    res = cur;
    case (cnt)
      byte_cnt_w'(2): res[23:16] = data;
      byte_cnt_w'(3): res[15:8]  = data;
      byte_cnt_w'(4): res[7:0]   = data;
      default:        res = cur;
    endcase
    return res;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // configuration registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      mapper      <= mapper_reset;
      rom_mask    <= '0;
      sram_mask   <= '0;
      featurebits <= '0;
    end else if (cmd_ready) begin
      if (cmd.f.group == grp_mapper) begin
        mapper <= cmd.code[2:0];
      end
    end else if (param_ready) begin
      if (cmd.f.group == grp_rom_mask) begin
        rom_mask <= load_mask_byte(rom_mask, param_data, byte_cnt);
      end
      if (cmd.f.group == grp_sram_mask) begin
        sram_mask <= load_mask_byte(sram_mask, param_data, byte_cnt);
      end
      if (cmd.code == code_features) begin
        featurebits <= param_data;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // pointer and memory strobes
  ////////////////////////////////////////////////////////////////////////////

  // target 3 falls back to the main pointer
  always_comb begin
    ptr_load = '0;
    if (param_ready && cmd.f.group == grp_ptr_load) begin
      case (cmd.f.target)
        tgt_audio:  ptr_load[tgt_audio]  = 1'b1;
        tgt_stream: ptr_load[tgt_stream] = 1'b1;
        default:    ptr_load[tgt_main]   = 1'b1;
      endcase
    end
  end

  // a read fires on the command byte too, a write only with data
  assign rd_start = !busy && (cmd_ready || param_ready) &&
                    (cmd.f.group == grp_mem_read);
  assign wr_start = !busy && param_ready && (cmd.f.group == grp_mem_write);

  assign xfer_target = cmd.f.target;
  assign xfer_incr   = cmd.f.incr;
  assign wr_data     = param_data;

endmodule

/* source/mcu_cmd_pkg.sv */
package mcu_cmd_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths and counts
  ////////////////////////////////////////////////////////////////////////////

  localparam int byte_cnt_w = 8;
  localparam int num_ptr    = 3;
  localparam int ptr_w_max  = 24;
  localparam int mask_w     = 24;

  // pointer widths per target: main, audio buffer, stream buffer
  localparam int ptr_w_table [num_ptr] = '{24, 11, 14};

  localparam logic [1:0] tgt_main   = 2'd0;
  localparam logic [1:0] tgt_audio  = 2'd1;
  localparam logic [1:0] tgt_stream = 2'd2;

  ////////////////////////////////////////////////////////////////////////////
  // command encoding
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [3:0] grp_ptr_load  = 4'h0;
  localparam logic [3:0] grp_rom_mask  = 4'h1;
  localparam logic [3:0] grp_sram_mask = 4'h2;
  localparam logic [3:0] grp_mapper    = 4'h3;
  localparam logic [3:0] grp_mem_read  = 4'h8;
  localparam logic [3:0] grp_mem_write = 4'h9;
  localparam logic [3:0] grp_info      = 4'hf;

  localparam logic [7:0] code_features = 8'hed;
  localparam logic [7:0] code_ident    = 8'hf0;
  localparam logic [7:0] code_status   = 8'hf1;
  localparam logic [7:0] code_echo     = 8'hff;

  localparam logic [7:0] ident_byte   = 8'ha5;
  localparam logic [2:0] mapper_reset = 3'd1;

  // memory request FSM states
  localparam logic [1:0] st_idle      = 2'd0;
  localparam logic [1:0] st_wait_ack  = 2'd1;
  localparam logic [1:0] st_wait_rel  = 2'd2;

  // command byte, seen as a full code or split into fields
  typedef union packed {
    logic [7:0] code;
    struct packed {
      logic [3:0] group;
      logic       incr;
      logic       spare;
      logic [1:0] target;
    } f;
  } cmd_word_u;

endpackage

/* source/mcu_cmd_top.sv */
`timescale 1ns/1ps

module mcu_cmd_top import mcu_cmd_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  cmd_ready,
  input  logic                  param_ready,
  input  logic [7:0]            cmd_data,
  input  logic [7:0]            param_data,
  input  logic [byte_cnt_w-1:0] byte_cnt,
  input  logic                  mem_ack,
  input  logic [7:0]            mem_rdata,
  output logic [2:0]            mapper,
  output logic [mask_w-1:0]     rom_mask,
  output logic [mask_w-1:0]     sram_mask,
  output logic [7:0]            featurebits,
  output logic                  mem_req,
  output logic                  mem_write,
  output logic [ptr_w_max-1:0]  mem_addr,
  output logic [7:0]            mem_wdata,
  output logic [7:0]            spi_data_out
);

  logic [num_ptr-1:0]           ptr_load;
  logic [num_ptr-1:0]           ptr_inc;
  logic [num_ptr*ptr_w_max-1:0] ptr_bus;
  logic                         rd_start;
  logic                         wr_start;
  logic [1:0]                   xfer_target;
  logic                         xfer_incr;
  logic [7:0]                   wr_data;
  logic                         rd_valid;
  logic [7:0]                   rd_byte;
  logic                         busy;

  cmd_decode u_decode (
    .clk         (clk),
    .reset       (reset),
    .cmd_ready   (cmd_ready),
    .param_ready (param_ready),
    .cmd_data    (cmd_data),
    .param_data  (param_data),
    .byte_cnt    (byte_cnt),
    .busy        (busy),
    .mapper      (mapper),
    .rom_mask    (rom_mask),
    .sram_mask   (sram_mask),
    .featurebits (featurebits),
    .ptr_load    (ptr_load),
    .rd_start    (rd_start),
    .wr_start    (wr_start),
    .xfer_target (xfer_target),
    .xfer_incr   (xfer_incr),
    .wr_data     (wr_data)
  );

  // one pointer per target, zero-extended onto the shared bus
  for (genvar i = 0; i < num_ptr; i++) begin : g_ptr
    logic [ptr_w_table[i]-1:0] ptr;

    addr_pointer #(.ptr_w(ptr_w_table[i])) u_ptr (
      .clk        (clk),
      .reset      (reset),
      .load       (ptr_load[i]),
      .inc        (ptr_inc[i]),
      .param_data (param_data),
      .byte_cnt   (byte_cnt),
      .ptr        (ptr)
    );

    assign ptr_bus[i*ptr_w_max +: ptr_w_max] = ptr_w_max'(ptr);
  end

  mem_access u_mem (
    .clk         (clk),
    .reset       (reset),
    .rd_start    (rd_start),
    .wr_start    (wr_start),
    .xfer_target (xfer_target),
    .xfer_incr   (xfer_incr),
    .wr_data     (wr_data),
    .ptr_bus     (ptr_bus),
    .mem_ack     (mem_ack),
    .mem_rdata   (mem_rdata),
    .mem_req     (mem_req),
    .mem_write   (mem_write),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .ptr_inc     (ptr_inc),
    .rd_valid    (rd_valid),
    .rd_byte     (rd_byte),
    .busy        (busy)
  );

  reply_mux u_reply (
    .clk          (clk),
    .reset        (reset),
    .cmd_ready    (cmd_ready),
    .param_ready  (param_ready),
    .cmd_data     (cmd_data),
    .param_data   (param_data),
    .rd_valid     (rd_valid),
    .rd_byte      (rd_byte),
    .busy         (busy),
    .mapper       (mapper),
    .spi_data_out (spi_data_out)
  );

endmodule

/* source/mem_access.sv */
`timescale 1ns/1ps

module mem_access import mcu_cmd_pkg::*; (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         rd_start,
  input  logic                         wr_start,
  input  logic [1:0]                   xfer_target,
  input  logic                         xfer_incr,
  input  logic [7:0]                   wr_data,
  input  logic [num_ptr*ptr_w_max-1:0] ptr_bus,
  input  logic                         mem_ack,
  input  logic [7:0]                   mem_rdata,
  output logic                         mem_req,
  output logic                         mem_write,
  output logic [ptr_w_max-1:0]         mem_addr,
  output logic [7:0]                   mem_wdata,
  output logic [num_ptr-1:0]           ptr_inc,
  output logic                         rd_valid,
  output logic [7:0]                   rd_byte,
  output logic                         busy
);

  logic [1:0]           state;
  logic [1:0]           sel;
  logic [1:0]           tgt_q;
  logic                 incr_q;
  logic [ptr_w_max-1:0] sel_ptr;

  // unused target code maps to main
  always_comb begin
    case (xfer_target)
      tgt_audio:  sel = tgt_audio;
      tgt_stream: sel = tgt_stream;
      default:    sel = tgt_main;
    endcase
  end

  assign sel_ptr = ptr_bus[int'(sel)*ptr_w_max +: ptr_w_max];
  assign busy    = (state != st_idle);

  ////////////////////////////////////////////////////////////////////////////
  // four-phase request FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= st_idle;
      mem_req   <= 1'b0;
      mem_write <= 1'b0;
      rd_valid  <= 1'b0;
      ptr_inc   <= '0;
    end else begin
      rd_valid <= 1'b0;
      ptr_inc  <= '0;
      case (state)
        st_idle: begin
          if (rd_start || wr_start) begin
            mem_req   <= 1'b1;
            mem_write <= wr_start;
            mem_addr  <= sel_ptr;
            mem_wdata <= wr_data;
            tgt_q     <= sel;
            incr_q    <= xfer_incr;
            state     <= st_wait_ack;
          end
        end
        st_wait_ack: begin
          if (mem_ack) begin
            mem_req  <= 1'b0;
            rd_valid <= !mem_write;
            rd_byte  <= mem_rdata;
            ptr_inc  <= incr_q ? (num_ptr'(1) << tgt_q) : '0;
            state    <= st_wait_rel;
          end
        end
        // hold off until the memory drops ack
        st_wait_rel: begin
          if (!mem_ack) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

/* source/reply_mux.sv */
`timescale 1ns/1ps

module reply_mux import mcu_cmd_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       cmd_ready,
  input  logic       param_ready,
  input  logic [7:0] cmd_data,
  input  logic [7:0] param_data,
  input  logic       rd_valid,
  input  logic [7:0] rd_byte,
  input  logic       busy,
  input  logic [2:0] mapper,
  output logic [7:0] spi_data_out
);

  cmd_word_u  cmd;
  logic [7:0] status_byte;

  assign cmd = cmd_data;

  // busy on top, mapper in the low bits
  assign status_byte = {busy, 4'b0000, mapper};

  ////////////////////////////////////////////////////////////////////////////
  // reply byte register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      spi_data_out <= '0;
    end else if (rd_valid) begin
      spi_data_out <= rd_byte;
    end else if ((cmd_ready || param_ready) && cmd.f.group == grp_info) begin
      case (cmd.code)
        code_ident: begin
          spi_data_out <= ident_byte;
        end
        code_status: begin
          spi_data_out <= status_byte;
        end
        code_echo: begin
          // echo the byte just received
          spi_data_out <= param_data;
        end
        default: begin
          spi_data_out <= spi_data_out;
        end
      endcase
    end
  end

endmodule

/* tb.f */
source/mcu_cmd_pkg.sv
source/cmd_decode.sv
source/addr_pointer.sv
source/mem_access.sv
source/reply_mux.sv
source/mcu_cmd_top.sv
test/tb_mcu_cmd.sv

/* test/tb_mcu_cmd.sv */
`timescale 1ns/1ps

module tb_mcu_cmd import mcu_cmd_pkg::*; ();

  localparam int max_cycles = 4000;

  logic                  clk = 1'b0;
  logic                  reset = 1'b1;
  logic                  cmd_ready = 1'b0;
  logic                  param_ready = 1'b0;
  logic [7:0]            cmd_data = '0;
  logic [7:0]            param_data = '0;
  logic [byte_cnt_w-1:0] byte_cnt = '0;
  logic                  mem_ack = 1'b0;
  logic [7:0]            mem_rdata = '0;
  logic [2:0]            mapper;
  logic [23:0]           rom_mask;
  logic [23:0]           sram_mask;
  logic [7:0]            featurebits;
  logic                  mem_req;
  logic                  mem_write;
  logic [23:0]           mem_addr;
  logic [7:0]            mem_wdata;
  logic [7:0]            spi_data_out;

  logic [31:0] lcg_state = 32'ha3d2_f015;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  logic [7:0]  mem [256];
  logic [7:0]  shadow [256];
  logic [23:0] exp_ptr [num_ptr];
  logic [23:0] exp_addr_q [$];
  logic        exp_write_q [$];
  logic [7:0]  exp_wdata_q [$];

  mcu_cmd_top UUT (.*);

  always #20 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // fill pattern over the full byte address
  function automatic logic [7:0] fill_byte(input int a);
    return 8'(a * 37 + 8'h1b);
  endfunction

  function automatic int alias_target(input int t);
    return (t == 3) ? 0 : t;
  endfunction

  function automatic logic [23:0] wrap_ptr(input int idx, input logic [31:0] v);
    return 24'(v & ((32'd1 << ptr_w_table[idx]) - 1));
  endfunction

  task automatic check_hex(
    input string       name,
    input logic [31:0] got,
    input logic [31:0] exp
  );
    checks++;
    assert (got === exp)
      else begin
        errors++;
        $display("ERR %s got %0h expected %0h at %0t", name, got, exp, $time);
      end
  endtask

  // inputs change 2 ns after the rising edge
  task automatic next_slot();
    @(posedge clk);
    #2;
  endtask

  task automatic wait_idle();
    while (UUT.busy) begin
      next_slot();
    end
  endtask

  // one ready pulse, then two idle cycles
  task automatic pulse_byte(input logic is_cmd, input logic [7:0] value, input int cnt);
    byte_cnt = byte_cnt_w'(cnt);
    if (is_cmd) begin
      cmd_data  = value;
      cmd_ready = 1'b1;
    end else begin
      param_data  = value;
      param_ready = 1'b1;
    end
    next_slot();
    cmd_ready   = 1'b0;
    param_ready = 1'b0;
    repeat (2) begin
      next_slot();
    end
  endtask

  // parameters packed msb first in params
  task automatic send_transaction(input logic [7:0] code, input logic [31:0] params, input int n);
    pulse_byte(1'b1, code, 1);
    for (int i = 0; i < n; i++) begin
      pulse_byte(1'b0, params[8*(n-1-i) +: 8], i + 2);
    end
  endtask

  task automatic load_pointer(input int t, input logic [31:0] value);
    int idx;
    idx = alias_target(t);
    send_transaction({grp_ptr_load, 2'b00, 2'(t)}, value, (ptr_w_table[idx] + 7) / 8);
    exp_ptr[idx] = wrap_ptr(idx, value);
  endtask

  task automatic run_reads(input int t, input logic incr, input int n);
    int          idx;
    logic [23:0] addr;
    idx = alias_target(t);
    for (int k = 0; k < n; k++) begin
      addr = exp_ptr[idx];
      exp_addr_q.push_back(addr);
      exp_write_q.push_back(1'b0);
      exp_wdata_q.push_back(8'h00);
      wait_idle();
      if (k == 0) begin
        pulse_byte(1'b1, {grp_mem_read, incr, 1'b0, 2'(t)}, 1);
      end else begin
        pulse_byte(1'b0, 8'(lcg_next() >> 16), k + 1);
      end
      wait_idle();
      check_hex("spi_data_out", spi_data_out, shadow[addr[7:0]]);
      if (incr) begin
        exp_ptr[idx] = wrap_ptr(idx, exp_ptr[idx] + 1);
      end
    end
  endtask

  task automatic run_writes(input int t, input int n);
    int          idx;
    logic [23:0] addr;
    logic [7:0]  data;
    idx = alias_target(t);
    wait_idle();
    pulse_byte(1'b1, {grp_mem_write, 1'b1, 1'b0, 2'(t)}, 1);
    for (int k = 0; k < n; k++) begin
      addr = exp_ptr[idx];
      data = 8'(lcg_next() >> 16);
      exp_addr_q.push_back(addr);
      exp_write_q.push_back(1'b1);
      exp_wdata_q.push_back(data);
      wait_idle();
      pulse_byte(1'b0, data, k + 2);
      wait_idle();
      shadow[addr[7:0]] = data;
      exp_ptr[idx] = wrap_ptr(idx, exp_ptr[idx] + 1);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // memory model
  ////////////////////////////////////////////////////////////////////////////

  // answers each request after 1 to 4 cycles
  initial begin
    int         lat;
    logic [7:0] a;
    logic [7:0] wdata;
    for (int i = 0; i < 256; i++) begin
      mem[i]    = fill_byte(i);
      shadow[i] = fill_byte(i);
    end
    forever begin
      next_slot();
      if (mem_req) begin
        lat = 1 + int'(lcg_next() >> 30);
        repeat (lat) begin
          next_slot();
        end
        a = mem_addr[7:0];
        assert (exp_addr_q.size() > 0)
          else begin
            errors++;
            $display("memory request arrived while no transfer was expected");
          end
        if (exp_addr_q.size() > 0) begin
          wdata = exp_wdata_q.pop_front();
          check_hex("mem_addr", mem_addr, exp_addr_q.pop_front());
          check_hex("mem_write", mem_write, exp_write_q.pop_front());
          if (mem_write) begin
            check_hex("mem_wdata", mem_wdata, wdata);
          end
        end
        if (mem_write) begin
          mem[a] = mem_wdata;
        end else begin
          mem_rdata = mem[a];
        end
        mem_ack = 1'b1;
        do begin
          next_slot();
        end while (mem_req);
        // ack lingers 0 to 3 cycles after req drops
        lat = int'(lcg_next() >> 30);
        repeat (lat) begin
          next_slot();
        end
        mem_ack = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // handshake rules
  ////////////////////////////////////////////////////////////////////////////

  req_rise_ack_low: assert property (@(posedge clk) disable iff (reset)
    $rose(mem_req) |-> !mem_ack)
    else begin
      errors++;
      $display("mem_req rose while mem_ack was still high");
    end

  req_fall_after_ack: assert property (@(posedge clk) disable iff (reset)
    $fell(mem_req) |-> $past(mem_ack))
    else begin
      errors++;
      $display("mem_req dropped before mem_ack was seen high");
    end

  req_addr_stable: assert property (@(posedge clk) disable iff (reset)
    (mem_req && $past(mem_req)) |-> ($stable(mem_addr) && $stable(mem_write)))
    else begin
      errors++;
      $display("mem_addr or mem_write moved while mem_req was high");
    end

  // budget is a few times the length of the sequence
  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("timeout, the run did not finish within %0d cycles", max_cycles);
      $display("errors %0d, value checks %0d", errors, checks);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] v;
    logic [2:0]  exp_mapper;
    repeat (10) begin
      @(posedge clk);
    end
    #2;
    reset = 1'b0;
    check_hex("mapper", mapper, 3'd1);
    check_hex("rom_mask", rom_mask, 24'h0);
    check_hex("sram_mask", sram_mask, 24'h0);
    check_hex("featurebits", featurebits, 8'h0);
    check_hex("mem_req", mem_req, 1'b0);
    check_hex("mem_write", mem_write, 1'b0);
    check_hex("spi_data_out", spi_data_out, 8'h0);

    send_transaction(8'h35, 32'h0, 0);
    exp_mapper = 3'd5;
    check_hex("mapper", mapper, exp_mapper);
    v = lcg_next() & 32'hff_ffff;
    send_transaction(8'h10, v, 3);
    check_hex("rom_mask", rom_mask, v);
    v = lcg_next() & 32'hff_ffff;
    send_transaction(8'h20, v, 3);
    check_hex("sram_mask", sram_mask, v);
    v = lcg_next() >> 24;
    send_transaction(code_features, v, 1);
    check_hex("featurebits", featurebits, v);

    send_transaction(code_ident, 32'h0, 0);
    check_hex("spi_data_out", spi_data_out, 8'ha5);
    v = lcg_next() >> 24;
    send_transaction(code_echo, v, 1);
    check_hex("spi_data_out", spi_data_out, v);
    send_transaction(code_status, 32'h0, 0);
    check_hex("spi_data_out", spi_data_out, {5'b0, exp_mapper});

    for (int t = 0; t < num_ptr; t++) begin
      load_pointer(t, lcg_next());
      run_reads(t, 1'b1, 6);
      run_reads(t, 1'b0, 3);
    end
    // audio pointer runs over its top, then target 3 reaches main
    load_pointer(1, 32'h07fd);
    run_reads(1, 1'b1, 6);
    load_pointer(3, lcg_next());
    run_reads(3, 1'b1, 3);

    v = lcg_next();
    load_pointer(2, v);
    run_writes(2, 5);
    load_pointer(2, v);
    run_reads(2, 1'b1, 5);

    wait_idle();
    send_transaction(code_status, 32'h0, 0);
    check_hex("spi_data_out", spi_data_out, {5'b0, exp_mapper});
    assert (exp_addr_q.size() == 0)
      else begin
        errors++;
        $display("%0d expected memory requests never arrived", exp_addr_q.size());
      end

    $display("errors %0d, value checks %0d", errors, checks);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
